/* files.f */
fsl_mem_pkg.sv
fsl_arbit.sv
fsl_axi_rd.sv
fsl_axi_wr.sv
fsl_mem_top.sv
tb_axi_mem.sv
tb_fsl_mem.sv

/* run_sim.sh */
#!/bin/sh
# build the testbench with Verilator, run it and look for the pass line
rm -f sim.log
verilator --binary --timing -f files.f --top-module tb_fsl_mem -o tb_fsl_mem_sim \
    && ./obj_dir/tb_fsl_mem_sim > sim.log 2>&1 \
    || echo "build or run did not complete"
grep -qx "STATUS: PASS" sim.log 2>/dev/null \
    && echo "simulation passed" \
    || { echo "simulation failed, see sim.log"; exit 1; }

/* tb_fsl_mem.sv */
module tb_fsl_mem;
    import fsl_mem_pkg::*;

    // about 40 requests of at most 25 cycles each, five times over
    localparam int TIMEOUT = 40 * 25 * 4 * 5;

    logic    clk;
    logic    rst_i;
    rd_req_t ic_req;
    dc_req_t dc_req;
    uc_req_t uc_req;
    rsp_t    ic_rsp;
    rsp_t    dc_rsp;
    rsp_t    uc_rsp;
    axi_ar_t ar;
    logic    ar_valid;
    logic    ar_ready;
    axi_r_t  r;
    logic    r_valid;
    logic    r_ready;
    axi_aw_t aw;
    logic    aw_valid;
    logic    aw_ready;
    axi_w_t  w;
    logic    w_valid;
    logic    w_ready;
    axi_b_t  b;
    logic    b_valid;
    logic    b_ready;

    data_t       shadow [256];      // expected memory contents
    int          err_cnt = 0;
    int          check_cnt = 0;
    logic [31:0] rng = 32'hebec;

    // bus monitor state
    logic    ar_hold = 1'b0;
    logic    aw_hold = 1'b0;
    logic    w_hold = 1'b0;
    axi_ar_t ar_prev;
    axi_aw_t aw_prev;
    axi_w_t  w_prev;
    time     ar_hs_time = 0;
    time     aw_hs_time = 0;
    axi_id_t last_ar_id;
    int      ic_rsp_cnt = 0;
    int      dc_rsp_cnt = 0;
    int      uc_rsp_cnt = 0;

    fsl_mem_top UUT (
        .clk(clk), .rst_i(rst_i),
        .ic_req_i(ic_req), .dc_req_i(dc_req), .uc_req_i(uc_req),
        .ic_rsp_o(ic_rsp), .dc_rsp_o(dc_rsp), .uc_rsp_o(uc_rsp),
        .axi_ar_o(ar), .axi_ar_valid_o(ar_valid), .axi_ar_ready_i(ar_ready),
        .axi_r_i(r), .axi_r_valid_i(r_valid), .axi_r_ready_o(r_ready),
        .axi_aw_o(aw), .axi_aw_valid_o(aw_valid), .axi_aw_ready_i(aw_ready),
        .axi_w_o(w), .axi_w_valid_o(w_valid), .axi_w_ready_i(w_ready),
        .axi_b_i(b), .axi_b_valid_i(b_valid), .axi_b_ready_o(b_ready)
    );

    tb_axi_mem mem_slave (
        .clk(clk), .rst_i(rst_i),
        .ar_i(ar), .ar_valid_i(ar_valid), .ar_ready_o(ar_ready),
        .r_o(r), .r_valid_o(r_valid), .r_ready_i(r_ready),
        .aw_i(aw), .aw_valid_i(aw_valid), .aw_ready_o(aw_ready),
        .w_i(w), .w_valid_i(w_valid), .w_ready_o(w_ready),
        .b_o(b), .b_valid_o(b_valid), .b_ready_i(b_ready)
    );

    initial clk = 1'b0;
    always #2 clk = ~clk;

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    task automatic check_eq(input logic [127:0] got, input logic [127:0] exp, input string msg);
        check_cnt++;
        if (got !== exp) begin
            err_cnt++;
            $display("CHECK FAILED at time %0t: %s (got %0h, expected %0h)", $time, msg, got, exp);
        end
    endtask

    // byte-masked update of the expected memory
    task automatic apply_write(input addr_t a, input data_t d, input strb_t m);
        for (int k = 0; k < 8; k++) begin
            if (m[k]) begin
                shadow[a[10:3]][k*8 +: 8] = d[k*8 +: 8];
            end
        end
    endtask

    function automatic rsp_t pick_rsp(input axi_id_t who);
        case (who)
            ID_ICACHE: return ic_rsp;
            ID_DCACHE: return dc_rsp;
            default:   return uc_rsp;
        endcase
    endfunction

    // outputs sampled on the falling edge, watchdog covers a lost refresh
    task automatic wait_rsp(input axi_id_t who, output data_t d);
        rsp_t rsp;
        do begin
            @(negedge clk);
            rsp = pick_rsp(who);
        end while (!rsp.refresh);
        d = rsp.data;
    endtask

    task automatic ic_read(input addr_t a, output data_t d);
        @(posedge clk);
        ic_req.re   <= 1'b1;
        ic_req.addr <= a;
        wait_rsp(ID_ICACHE, d);
        @(posedge clk);
        ic_req.re <= 1'b0;
    endtask

    task automatic dc_wb_refill(input addr_t wb_a, input data_t wb_d, input addr_t a,
                                output data_t d);
        @(posedge clk);
        dc_req.re      <= 1'b1;
        dc_req.we      <= 1'b1;
        dc_req.addr    <= a;
        dc_req.wb_addr <= wb_a;
        dc_req.wb_data <= wb_d;
        wait_rsp(ID_DCACHE, d);
        @(posedge clk);
        dc_req.re <= 1'b0;
        dc_req.we <= 1'b0;
        apply_write(wb_a, wb_d, 8'hff);     // whole line written back
    endtask

    task automatic uc_write(input addr_t a, input data_t wd, input strb_t m, output data_t d);
        @(posedge clk);
        uc_req.we    <= 1'b1;
        uc_req.addr  <= a;
        uc_req.wdata <= wd;
        uc_req.mask  <= m;
        wait_rsp(ID_UNCACHE, d);
        @(posedge clk);
        uc_req.we <= 1'b0;
        apply_write(a, wd, m);
    endtask

    task automatic uc_read(input addr_t a, output data_t d);
        @(posedge clk);
        uc_req.re   <= 1'b1;
        uc_req.addr <= a;
        wait_rsp(ID_UNCACHE, d);
        @(posedge clk);
        uc_req.re <= 1'b0;
    endtask

    task automatic test_icache_read();
        addr_t a;
        data_t got;
        int    cnt0;
        a    = 32'h0000_0128;
        cnt0 = ic_rsp_cnt;
        ic_read(a, got);
        repeat (20) @(negedge clk);     // long enough for a repeated transaction
        check_eq(128'(got), 128'(shadow[a[10:3]]), "icache read data");
        check_eq(128'(last_ar_id), 128'(ID_ICACHE), "icache AR id");
        check_eq(128'(ic_rsp_cnt - cnt0), 128'(1), "icache refresh count");
    endtask

    task automatic test_uncache_masked_write();
        addr_t a;
        data_t old;
        data_t wd;
        data_t got;
        a   = 32'h0000_0240;
        old = shadow[a[10:3]];
        wd  = 64'h1122_3344_5566_7788;
        uc_write(a, wd, 8'h0f, got);
        check_eq(128'(got), 128'(0), "uncache write refresh data");
        uc_read(a, got);
        check_eq(128'(got), 128'({old[63:32], wd[31:0]}), "uncache masked read-back");
    endtask

    task automatic test_dcache_writeback_refill();
        addr_t wb_a;
        addr_t a;
        data_t wb_d;
        data_t exp;
        data_t got;
        int    cnt0;
        wb_a       = 32'h0000_0380;
        a          = 32'h0000_04c8;
        wb_d       = 64'hdead_beef_0bad_f00d;
        exp        = shadow[a[10:3]];
        aw_hs_time = 0;
        ar_hs_time = 0;
        cnt0       = dc_rsp_cnt;
        dc_wb_refill(wb_a, wb_d, a, got);
        repeat (20) @(negedge clk);
        check_eq(128'(got), 128'(exp), "dcache refill data");
        check_eq(128'(dc_rsp_cnt - cnt0), 128'(1), "dcache refresh count");
        check_eq(128'(aw_hs_time != 0 && ar_hs_time > aw_hs_time), 128'(1),
                 "write-back AW not ahead of refill AR");
        uc_read(wb_a, got);
        check_eq(128'(got), 128'(wb_d), "write-back line in memory");
    endtask

    task automatic test_priority();
        axi_id_t order [3];
        axi_id_t who;
        addr_t   a_ic;
        addr_t   a_dc;
        addr_t   a_uc;
        data_t   exp;
        rsp_t    rsp;
        order = '{ID_DCACHE, ID_ICACHE, ID_UNCACHE};
        a_ic  = 32'h0000_0010;
        a_dc  = 32'h0000_0618;
        a_uc  = 32'h0000_07f8;
        @(posedge clk);
        ic_req.re   <= 1'b1;
        ic_req.addr <= a_ic;
        dc_req.re   <= 1'b1;
        dc_req.addr <= a_dc;
        uc_req.re   <= 1'b1;
        uc_req.addr <= a_uc;
        for (int k = 0; k < 3; k++) begin
            do begin
                @(negedge clk);
            end while (!(ic_rsp.refresh || dc_rsp.refresh || uc_rsp.refresh));
            who = dc_rsp.refresh ? ID_DCACHE : (ic_rsp.refresh ? ID_ICACHE : ID_UNCACHE);
            rsp = pick_rsp(who);
            exp = shadow[(who == ID_DCACHE) ? a_dc[10:3] :
                         ((who == ID_ICACHE) ? a_ic[10:3] : a_uc[10:3])];
            check_eq(128'(who), 128'(order[k]), "refresh out of priority order");
            check_eq(128'(rsp.data), 128'(exp), "read data under contention");
            @(posedge clk);
            case (who)
                ID_DCACHE: dc_req.re <= 1'b0;
                ID_ICACHE: ic_req.re <= 1'b0;
                default:   uc_req.re <= 1'b0;
            endcase
        end
    endtask

    task automatic test_random_traffic();
        addr_t a;
        addr_t wb_a;
        data_t wd;
        data_t got;
        strb_t m;
        for (int n = 0; n < 30; n++) begin
            rng  = xorshift32(rng);
            a    = {21'd0, rng[15:8], 3'd0};
            wb_a = {21'd0, rng[23:16], 3'd0};
            m    = rng[31:24];
            wd   = {xorshift32(rng), ~rng};
            case (rng[1:0])
                2'd0: begin
                    ic_read(a, got);
                    check_eq(128'(got), 128'(shadow[a[10:3]]), "random icache read");
                end
                2'd1: begin
                    dc_wb_refill(wb_a, wd, a, got);     // refill may hit the written line
                    check_eq(128'(got), 128'(shadow[a[10:3]]), "random dcache refill");
                end
                2'd2: begin
                    uc_write(a, wd, m, got);
                    check_eq(128'(got), 128'(0), "random uncache write refresh");
                end
                default: begin
                    uc_read(a, got);
                    check_eq(128'(got), 128'(shadow[a[10:3]]), "random uncache read");
                end
            endcase
        end
    endtask

    // payload stability under back-pressure, handshake order, refresh counts
    always @(negedge clk) begin
        if (!rst_i) begin
            if (ar_hold) begin
                check_eq(128'(ar_valid), 128'(1), "ar_valid dropped before ar_ready");
                check_eq(128'(ar), 128'(ar_prev), "AR payload changed while stalled");
            end
            if (aw_hold) begin
                check_eq(128'(aw_valid), 128'(1), "aw_valid dropped before aw_ready");
                check_eq(128'(aw), 128'(aw_prev), "AW payload changed while stalled");
            end
            if (w_hold) begin
                check_eq(128'(w_valid), 128'(1), "w_valid dropped before w_ready");
                check_eq(128'(w), 128'(w_prev), "W payload changed while stalled");
            end
            ar_hold = ar_valid && !ar_ready;
            aw_hold = aw_valid && !aw_ready;
            w_hold  = w_valid && !w_ready;
            ar_prev = ar;
            aw_prev = aw;
            w_prev  = w;
            if (ar_valid && ar_ready) begin
                ar_hs_time = $time;
                last_ar_id = ar.id;
                // one beat of 8 bytes, incrementing
                check_eq(128'({ar.len, ar.size, ar.burst}), 128'({8'd0, 3'd3, 2'd1}),
                         "AR length, size or burst wrong");
            end
            if (aw_valid && aw_ready) begin
                aw_hs_time = $time;
                check_eq(128'({aw.len, aw.size, aw.burst}), 128'({8'd0, 3'd3, 2'd1}),
                         "AW length, size or burst wrong");
            end
            if (w_valid && w_ready) begin
                check_eq(128'(w.last), 128'(1), "W beat without last");
            end
            check_eq(128'($countones({ic_rsp.refresh, dc_rsp.refresh, uc_rsp.refresh}) <= 1),
                     128'(1), "more than one refresh in a cycle");
            ic_rsp_cnt += int'(ic_rsp.refresh);
            dc_rsp_cnt += int'(dc_rsp.refresh);
            uc_rsp_cnt += int'(uc_rsp.refresh);
        end
    end

    initial begin
        #TIMEOUT;
        $display("timeout: the tests did not finish within %0d time units", TIMEOUT);
        $display("STATUS: FAIL");
        $finish;
    end

    initial begin
        ic_req = '0;
        dc_req = '0;
        uc_req = '0;
        rst_i  = 1'b1;
        repeat (8) @(posedge clk);
        rst_i <= 1'b0;
        for (int i = 0; i < 256; i++) begin
            shadow[i] = mem_slave.mem[i];   // preload pattern of the slave
        end
        @(negedge clk);
        check_eq(128'({ar_valid, aw_valid, w_valid, r_ready, b_ready,
                       ic_rsp.refresh, dc_rsp.refresh, uc_rsp.refresh}), 128'(0),
                 "handshake outputs not idle after reset");
        test_icache_read();
        test_uncache_masked_write();
        test_dcache_writeback_refill();
        test_priority();
        test_random_traffic();
        repeat (4) @(posedge clk);
        $display("checks: %0d, errors: %0d", check_cnt, err_cnt);
        if (err_cnt == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

/* tb_axi_mem.sv */
module tb_axi_mem (
    input  logic                 clk,
    input  logic                 rst_i,
    input  fsl_mem_pkg::axi_ar_t ar_i,
    input  logic                 ar_valid_i,
    output logic                 ar_ready_o,
    output fsl_mem_pkg::axi_r_t  r_o,
    output logic                 r_valid_o,
    input  logic                 r_ready_i,
    input  fsl_mem_pkg::axi_aw_t aw_i,
    input  logic                 aw_valid_i,
    output logic                 aw_ready_o,
    input  fsl_mem_pkg::axi_w_t  w_i,
    input  logic                 w_valid_i,
    output logic                 w_ready_o,
    output fsl_mem_pkg::axi_b_t  b_o,
    output logic                 b_valid_o,
    input  logic                 b_ready_i
);
    import fsl_mem_pkg::*;

    data_t       mem [256];     // indexed by addr[10:3]
    logic [31:0] rng_q;
    logic [1:0]  ar_wait_q;
    logic [1:0]  r_wait_q;
    logic [1:0]  aw_wait_q;
    logic [1:0]  w_wait_q;
    logic [1:0]  b_wait_q;
    logic        rd_pend_q;     // AR taken, R not yet sent
    logic        aw_got_q;
    logic        w_got_q;
    logic        b_pend_q;
    axi_ar_t     ar_q;
    axi_aw_t     aw_q;
    axi_w_t      w_q;

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    initial begin
        for (int i = 0; i < 256; i++) begin
            // odd multiplier keeps every word distinct
            mem[i] = {32'(i) ^ 32'ha5a5_0000, 32'(i) * 32'h9e37_79b9};
        end
        ar_ready_o = 1'b0;
        r_o        = '0;
        r_valid_o  = 1'b0;
        aw_ready_o = 1'b0;
        w_ready_o  = 1'b0;
        b_o        = '0;
        b_valid_o  = 1'b0;
    end

    always @(posedge clk) begin
        if (rst_i) begin
            rng_q      <= 32'hebec;
            ar_ready_o <= 1'b0;
            r_valid_o  <= 1'b0;
            aw_ready_o <= 1'b0;
            w_ready_o  <= 1'b0;
            b_valid_o  <= 1'b0;
            rd_pend_q  <= 1'b0;
            aw_got_q   <= 1'b0;
            w_got_q    <= 1'b0;
            b_pend_q   <= 1'b0;
            ar_wait_q  <= 2'd0;
            r_wait_q   <= 2'd0;
            aw_wait_q  <= 2'd0;
            w_wait_q   <= 2'd0;
            b_wait_q   <= 2'd0;
        end else begin
            rng_q <= xorshift32(rng_q);     // fresh delays every cycle

            // read address
            if (ar_valid_i && ar_ready_o) begin
                ar_ready_o <= 1'b0;
                ar_q       <= ar_i;
                rd_pend_q  <= 1'b1;
                ar_wait_q  <= rng_q[1:0];
            end else if (ar_valid_i && !rd_pend_q) begin
                if (ar_wait_q == 2'd0) begin
                    ar_ready_o <= 1'b1;
                end else begin
                    ar_wait_q <= ar_wait_q - 2'd1;
                end
            end

            // read data, id echoed
            if (r_valid_o && r_ready_i) begin
                r_valid_o <= 1'b0;
                rd_pend_q <= 1'b0;
                r_wait_q  <= rng_q[3:2];
            end else if (rd_pend_q && !r_valid_o) begin
                if (r_wait_q == 2'd0) begin
                    r_valid_o <= 1'b1;
                    r_o.id    <= ar_q.id;
                    r_o.data  <= mem[ar_q.addr[10:3]];
                    r_o.resp  <= 2'd0;
                    r_o.last  <= 1'b1;
                end else begin
                    r_wait_q <= r_wait_q - 2'd1;
                end
            end

            // write address and data, accepted in either order
            if (aw_valid_i && aw_ready_o) begin
                aw_ready_o <= 1'b0;
                aw_q       <= aw_i;
                aw_got_q   <= 1'b1;
                aw_wait_q  <= rng_q[5:4];
            end else if (aw_valid_i && !aw_got_q && !b_pend_q) begin
                if (aw_wait_q == 2'd0) begin
                    aw_ready_o <= 1'b1;
                end else begin
                    aw_wait_q <= aw_wait_q - 2'd1;
                end
            end
            if (w_valid_i && w_ready_o) begin
                w_ready_o <= 1'b0;
                w_q       <= w_i;
                w_got_q   <= 1'b1;
                w_wait_q  <= rng_q[7:6];
            end else if (w_valid_i && !w_got_q && !b_pend_q) begin
                if (w_wait_q == 2'd0) begin
                    w_ready_o <= 1'b1;
                end else begin
                    w_wait_q <= w_wait_q - 2'd1;
                end
            end

            if (aw_got_q && w_got_q) begin
                for (int k = 0; k < 8; k++) begin
                    if (w_q.strb[k]) begin
                        mem[aw_q.addr[10:3]][k*8 +: 8] <= w_q.data[k*8 +: 8];
                    end
                end
                aw_got_q <= 1'b0;
                w_got_q  <= 1'b0;
                b_pend_q <= 1'b1;
            end

            if (b_valid_o && b_ready_i) begin
                b_valid_o <= 1'b0;
                b_pend_q  <= 1'b0;
                b_wait_q  <= rng_q[9:8];
            end else if (b_pend_q && !b_valid_o) begin
                if (b_wait_q == 2'd0) begin
                    b_valid_o <= 1'b1;
                    b_o.id    <= aw_q.id;
                    b_o.resp  <= 2'd0;
                end else begin
                    b_wait_q <= b_wait_q - 2'd1;
                end
            end
        end
    end

endmodule

/* fsl_mem_top.sv */
module fsl_mem_top (
    input  logic                 clk,
    input  logic                 rst_i,
    input  fsl_mem_pkg::rd_req_t ic_req_i,
    input  fsl_mem_pkg::dc_req_t dc_req_i,
    input  fsl_mem_pkg::uc_req_t uc_req_i,
    output fsl_mem_pkg::rsp_t    ic_rsp_o,
    output fsl_mem_pkg::rsp_t    dc_rsp_o,
    output fsl_mem_pkg::rsp_t    uc_rsp_o,
    output fsl_mem_pkg::axi_ar_t axi_ar_o,
    output logic                 axi_ar_valid_o,
    input  logic                 axi_ar_ready_i,
    input  fsl_mem_pkg::axi_r_t  axi_r_i,
    input  logic                 axi_r_valid_i,
    output logic                 axi_r_ready_o,
    output fsl_mem_pkg::axi_aw_t axi_aw_o,
    output logic                 axi_aw_valid_o,
    input  logic                 axi_aw_ready_i,
    output fsl_mem_pkg::axi_w_t  axi_w_o,
    output logic                 axi_w_valid_o,
    input  logic                 axi_w_ready_i,
    input  fsl_mem_pkg::axi_b_t  axi_b_i,
    input  logic                 axi_b_valid_i,
    output logic                 axi_b_ready_o
);
    import fsl_mem_pkg::*;

    rd_cmd_t rd_cmd;
    wr_cmd_t wr_cmd;
    logic    rd_done;
    data_t   rd_data;
    logic    wr_done;

    fsl_arbit arbitu (
        .clk        (clk        ),
        .rst_i      (rst_i      ),
        .ic_req_i   (ic_req_i   ),
        .dc_req_i   (dc_req_i   ),
        .uc_req_i   (uc_req_i   ),
        .ic_rsp_o   (ic_rsp_o   ),
        .dc_rsp_o   (dc_rsp_o   ),
        .uc_rsp_o   (uc_rsp_o   ),
        .rd_cmd_o   (rd_cmd     ),
        .rd_done_i  (rd_done    ),
        .rd_data_i  (rd_data    ),
        .wr_cmd_o   (wr_cmd     ),
        .wr_done_i  (wr_done    )
    );

    // AR and R channels
    fsl_axi_rd axi_rdu (
        .clk        (clk            ),
        .rst_i      (rst_i          ),
        .cmd_i      (rd_cmd         ),
        .done_o     (rd_done        ),
        .data_o     (rd_data        ),
        .ar_o       (axi_ar_o       ),
        .ar_valid_o (axi_ar_valid_o ),
        .ar_ready_i (axi_ar_ready_i ),
        .r_i        (axi_r_i        ),
        .r_valid_i  (axi_r_valid_i  ),
        .r_ready_o  (axi_r_ready_o  )
    );

    // AW, W and B channels
    fsl_axi_wr axi_wru (
        .clk        (clk            ),
        .rst_i      (rst_i          ),
        .cmd_i      (wr_cmd         ),
        .done_o     (wr_done        ),
        .aw_o       (axi_aw_o       ),
        .aw_valid_o (axi_aw_valid_o ),
        .aw_ready_i (axi_aw_ready_i ),
        .w_o        (axi_w_o        ),
        .w_valid_o  (axi_w_valid_o  ),
        .w_ready_i  (axi_w_ready_i  ),
        .b_i        (axi_b_i        ),
        .b_valid_i  (axi_b_valid_i  ),
        .b_ready_o  (axi_b_ready_o  )
    );

endmodule

/* fsl_axi_wr.sv */
module fsl_axi_wr (
    input  logic                 clk,
    input  logic                 rst_i,
    input  fsl_mem_pkg::wr_cmd_t cmd_i,
    output logic                 done_o,
    output fsl_mem_pkg::axi_aw_t aw_o,
    output logic                 aw_valid_o,
    input  logic                 aw_ready_i,
    output fsl_mem_pkg::axi_w_t  w_o,
    output logic                 w_valid_o,
    input  logic                 w_ready_i,
    input  fsl_mem_pkg::axi_b_t  b_i,
    input  logic                 b_valid_i,
    output logic                 b_ready_o
);
    import fsl_mem_pkg::*;

    wr_state_t state_q;
    axi_aw_t   aw_q;
    axi_w_t    w_q;
    logic      aw_pend_q;   // AW not yet accepted
    logic      w_pend_q;    // W not yet accepted
    logic      done_q;
    logic      aw_fire;
    logic      w_fire;
    logic      aw_clear;
    logic      w_clear;

    assign aw_fire = aw_pend_q && aw_ready_i;
    assign w_fire  = w_pend_q && w_ready_i;

    // either channel may finish first
    assign aw_clear = aw_fire || !aw_pend_q;
    assign w_clear  = w_fire || !w_pend_q;

    always_ff @(posedge clk) begin
        if (rst_i) begin
            state_q   <= WR_IDLE;
            aw_pend_q <= 1'b0;
            w_pend_q  <= 1'b0;
            done_q    <= 1'b0;
        end else begin
            done_q <= 1'b0;
            case (state_q)
                WR_IDLE: begin
                    if (cmd_i.start) begin
                        aw_q.id    <= ID_DCACHE;    // writes share one id
                        aw_q.addr  <= cmd_i.addr;
                        aw_q.len   <= AXI_LEN_SINGLE;
                        aw_q.size  <= AXI_SIZE_8B;
                        aw_q.burst <= AXI_BURST_INCR;
                        w_q.data   <= cmd_i.data;
                        w_q.strb   <= cmd_i.strb;
                        w_q.last   <= 1'b1;         // always a single beat
                        aw_pend_q  <= 1'b1;
                        w_pend_q   <= 1'b1;
                        state_q    <= WR_SEND;
                    end
                end
                WR_SEND: begin
                    if (aw_fire) begin
                        aw_pend_q <= 1'b0;
                    end
                    if (w_fire) begin
                        w_pend_q <= 1'b0;
                    end
                    if (aw_clear && w_clear) begin
                        state_q <= WR_RESP;
                    end
                end
                WR_RESP: begin
                    if (b_valid_i) begin    // response code not checked
                        done_q  <= 1'b1;
                        state_q <= WR_IDLE;
                    end
                end
                default: state_q <= WR_IDLE;
            endcase
        end
    end

    assign aw_o       = aw_q;
    assign aw_valid_o = aw_pend_q;
    assign w_o        = w_q;
    assign w_valid_o  = w_pend_q;
    assign b_ready_o  = (state_q == WR_RESP);
    assign done_o     = done_q;

endmodule

/* fsl_axi_rd.sv */
module fsl_axi_rd (
    input  logic                 clk,
    input  logic                 rst_i,
    input  fsl_mem_pkg::rd_cmd_t cmd_i,
    output logic                 done_o,
    output fsl_mem_pkg::data_t   data_o,
    output fsl_mem_pkg::axi_ar_t ar_o,
    output logic                 ar_valid_o,
    input  logic                 ar_ready_i,
    input  fsl_mem_pkg::axi_r_t  r_i,
    input  logic                 r_valid_i,
    output logic                 r_ready_o
);
    import fsl_mem_pkg::*;

    rd_state_t state_q;
    axi_ar_t   ar_q;        // held stable while ar_valid is up
    data_t     data_q;
    logic      done_q;

    always_ff @(posedge clk) begin
        if (rst_i) begin
            state_q <= RD_IDLE;
            done_q  <= 1'b0;
        end else begin
            done_q <= 1'b0;
            case (state_q)
                RD_IDLE: begin
                    if (cmd_i.start) begin
                        ar_q.id    <= cmd_i.id;
                        ar_q.addr  <= cmd_i.addr;
                        ar_q.len   <= AXI_LEN_SINGLE;
                        ar_q.size  <= AXI_SIZE_8B;
                        ar_q.burst <= AXI_BURST_INCR;
                        state_q    <= RD_ADDR;
                    end
                end
                RD_ADDR: begin
                    if (ar_ready_i) begin   // AR accepted
                        state_q <= RD_DATA;
                    end
                end
                RD_DATA: begin
                    // single beat, so the first R beat ends the read
                    if (r_valid_i) begin
                        data_q  <= r_i.data;
                        done_q  <= 1'b1;
                        state_q <= RD_IDLE;
                    end
                end
                default: state_q <= RD_IDLE;
            endcase
        end
    end

    assign ar_o       = ar_q;
    assign ar_valid_o = (state_q == RD_ADDR);
    assign r_ready_o  = (state_q == RD_DATA);
    assign done_o     = done_q;
    assign data_o     = data_q;

endmodule

/* fsl_arbit.sv */
module fsl_arbit (
    input  logic                 clk,
    input  logic                 rst_i,
    input  fsl_mem_pkg::rd_req_t ic_req_i,
    input  fsl_mem_pkg::dc_req_t dc_req_i,
    input  fsl_mem_pkg::uc_req_t uc_req_i,
    output fsl_mem_pkg::rsp_t    ic_rsp_o,
    output fsl_mem_pkg::rsp_t    dc_rsp_o,
    output fsl_mem_pkg::rsp_t    uc_rsp_o,
    output fsl_mem_pkg::rd_cmd_t rd_cmd_o,
    input  logic                 rd_done_i,
    input  fsl_mem_pkg::data_t   rd_data_i,
    output fsl_mem_pkg::wr_cmd_t wr_cmd_o,
    input  logic                 wr_done_i
);
    import fsl_mem_pkg::*;

    arb_state_t state_q;
    axi_id_t    owner_q;    // requester holding the grant
    data_t      data_q;     // returned with the refresh
    rd_cmd_t    rd_cmd_q;
    wr_cmd_t    wr_cmd_q;

    always_ff @(posedge clk) begin
        if (rst_i) begin
            state_q        <= ARB_IDLE;
            owner_q        <= ID_ICACHE;
            rd_cmd_q.start <= 1'b0;
            wr_cmd_q.start <= 1'b0;
        end else begin
            rd_cmd_q.start <= 1'b0;     // single-cycle pulses
            wr_cmd_q.start <= 1'b0;
            case (state_q)
                ARB_IDLE: begin
                    // fixed priority: dcache, icache, uncache
                    if (dc_req_i.we) begin
                        owner_q        <= ID_DCACHE;
                        wr_cmd_q.start <= 1'b1;
                        wr_cmd_q.addr  <= dc_req_i.wb_addr;
                        wr_cmd_q.data  <= dc_req_i.wb_data;
                        wr_cmd_q.strb  <= '1;   // whole line
                        state_q        <= ARB_WB;
                    end else if (dc_req_i.re) begin
                        owner_q        <= ID_DCACHE;
                        rd_cmd_q.start <= 1'b1;
                        rd_cmd_q.id    <= ID_DCACHE;
                        rd_cmd_q.addr  <= dc_req_i.addr;
                        state_q        <= ARB_RD;
                    end else if (ic_req_i.re) begin
                        owner_q        <= ID_ICACHE;
                        rd_cmd_q.start <= 1'b1;
                        rd_cmd_q.id    <= ID_ICACHE;
                        rd_cmd_q.addr  <= ic_req_i.addr;
                        state_q        <= ARB_RD;
                    end else if (uc_req_i.we) begin
                        owner_q        <= ID_UNCACHE;
                        wr_cmd_q.start <= 1'b1;
                        wr_cmd_q.addr  <= uc_req_i.addr;
                        wr_cmd_q.data  <= uc_req_i.wdata;
                        wr_cmd_q.strb  <= uc_req_i.mask;
                        state_q        <= ARB_WR;
                    end else if (uc_req_i.re) begin
                        owner_q        <= ID_UNCACHE;
                        rd_cmd_q.start <= 1'b1;
                        rd_cmd_q.id    <= ID_UNCACHE;
                        rd_cmd_q.addr  <= uc_req_i.addr;
                        state_q        <= ARB_RD;
                    end
                end
                ARB_WB: begin
                    if (wr_done_i) begin
                        if (dc_req_i.re) begin  // refill follows the write-back
                            rd_cmd_q.start <= 1'b1;
                            rd_cmd_q.id    <= ID_DCACHE;
                            rd_cmd_q.addr  <= dc_req_i.addr;
                            state_q        <= ARB_RD;
                        end else begin
                            data_q  <= '0;
                            state_q <= ARB_DONE;
                        end
                    end
                end
                ARB_RD: begin
                    if (rd_done_i) begin
                        data_q  <= rd_data_i;
                        state_q <= ARB_DONE;
                    end
                end
                ARB_WR: begin
                    if (wr_done_i) begin
                        data_q  <= '0;      // writes answer with zero data
                        state_q <= ARB_DONE;
                    end
                end
                ARB_DONE: state_q <= ARB_IDLE;  // refresh is out this cycle
                default:  state_q <= ARB_IDLE;
            endcase
        end
    end

    assign rd_cmd_o = rd_cmd_q;
    assign wr_cmd_o = wr_cmd_q;

    // refresh and data go to the owner only
    always_comb begin
        ic_rsp_o = '0;
        dc_rsp_o = '0;
        uc_rsp_o = '0;
        if (state_q == ARB_DONE) begin
            case (owner_q)
                ID_ICACHE: begin
                    ic_rsp_o.refresh = 1'b1;
                    ic_rsp_o.data    = data_q;
                end
                ID_DCACHE: begin
                    dc_rsp_o.refresh = 1'b1;
                    dc_rsp_o.data    = data_q;
                end
                ID_UNCACHE: begin
                    uc_rsp_o.refresh = 1'b1;
                    uc_rsp_o.data    = data_q;
                end
                default: ;
            endcase
        end
    end

endmodule

/* fsl_mem_pkg.sv */
package fsl_mem_pkg;

    // widths fixed by the bus
    typedef logic [31:0] addr_t;
    typedef logic [63:0] data_t;       // one line in this design
    typedef logic [7:0]  strb_t;
    typedef logic [3:0]  axi_id_t;
    typedef logic [7:0]  axi_len_t;
    typedef logic [2:0]  axi_size_t;
    typedef logic [1:0]  axi_burst_t;
    typedef logic [1:0]  axi_resp_t;

    // transaction ids, one per requester
    localparam axi_id_t ID_ICACHE  = 4'd0;
    localparam axi_id_t ID_DCACHE  = 4'd1;
    localparam axi_id_t ID_UNCACHE = 4'd2;

    localparam axi_len_t   AXI_LEN_SINGLE = 8'd0;   // one beat
    localparam axi_size_t  AXI_SIZE_8B    = 3'd3;
    localparam axi_burst_t AXI_BURST_INCR = 2'd1;

    // requests held as levels until the refresh pulse
    typedef struct packed {
        logic  re;
        addr_t addr;
    } rd_req_t;

    typedef struct packed {
        logic  re;
        logic  we;         // write-back of the victim line
        addr_t addr;       // refill address
        addr_t wb_addr;
        data_t wb_data;
    } dc_req_t;

    typedef struct packed {
        logic  re;
        logic  we;
        addr_t addr;
        data_t wdata;
        strb_t mask;
    } uc_req_t;

    typedef struct packed {
        logic  refresh;
        data_t data;
    } rsp_t;

    // arbiter to channel masters
    typedef struct packed {
        logic    start;
        axi_id_t id;
        addr_t   addr;
    } rd_cmd_t;

    typedef struct packed {
        logic  start;
        addr_t addr;
        data_t data;
        strb_t strb;
    } wr_cmd_t;

    // AXI4 channel payloads
    typedef struct packed {
        axi_id_t    id;
        addr_t      addr;
        axi_len_t   len;
        axi_size_t  size;
        axi_burst_t burst;
    } axi_ar_t;

    typedef struct packed {
        axi_id_t    id;
        addr_t      addr;
        axi_len_t   len;
        axi_size_t  size;
        axi_burst_t burst;
    } axi_aw_t;

    typedef struct packed {
        data_t data;
        strb_t strb;
        logic  last;
    } axi_w_t;

    typedef struct packed {
        axi_id_t   id;
        data_t     data;
        axi_resp_t resp;
        logic      last;
    } axi_r_t;

    typedef struct packed {
        axi_id_t   id;
        axi_resp_t resp;
    } axi_b_t;

    typedef enum logic [2:0] {
        ARB_IDLE,
        ARB_WB,
        ARB_RD,
        ARB_WR,
        ARB_DONE
    } arb_state_t;

    typedef enum logic [1:0] {
        RD_IDLE,
        RD_ADDR,
        RD_DATA
    } rd_state_t;

    typedef enum logic [1:0] {
        WR_IDLE,
        WR_SEND,
        WR_RESP
    } wr_state_t;

endpackage
